//--- Makefile
VERILATOR ?= verilator
TOP ?= tlb_tb
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
SIM_ARGS ?= +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- files.f
verilog/tlb_pkg.sv
verilog/simple_ram.sv
verilog/simple_ram_init.sv
verilog/tlb_way.sv
verilog/tlb_resolve.sv
verilog/tlb_top.sv
tb/tlb_sva.sv
tb/tlb_tb.sv

//--- tb/tlb_sva.sv
// Translation cache port assertions
`timescale 1ns/10ps
`default_nettype none

module tlb_sva
    import tlb_pkg::*;
(
    input wire logic clk,
    input wire logic reset,
    input wire logic rdy,
    input wire logic req_valid,
    input wire tlb_req_t req,
    input wire logic credit_return,
    input wire logic rsp_valid,
    input wire logic rsp_deq
);

    // Failed assertions so far, read by the testbench at the end of the run
    int unsigned fail_count = 0;

    // Every handshake output comes out of reset low
    reset_outputs_low: assert property (@(posedge clk)
        reset |=> !rdy && !rsp_valid && !credit_return)
    else
    begin
        fail_count++;
        $error("rdy, rsp_valid or credit_return high right after reset");
    end

    // Once both init walks finish the cache stays ready
    rdy_stays_high: assert property (@(posedge clk) disable iff (reset)
        rdy |=> rdy)
    else
    begin
        fail_count++;
        $error("rdy fell after it had risen");
    end

    // A credit only comes back in the cycle after a real dequeue
    credit_after_deq: assert property (@(posedge clk) disable iff (reset)
        credit_return |-> $past(rsp_deq && rsp_valid))
    else
    begin
        fail_count++;
        $error("credit_return without a dequeue in the previous cycle");
    end

    deq_gives_credit: assert property (@(posedge clk) disable iff (reset)
        (rsp_deq && rsp_valid) |=> credit_return)
    else
    begin
        fail_count++;
        $error("dequeue was not followed by credit_return");
    end

    // The response enters the queue at the third edge after acceptance
    lookup_to_valid: assert property (@(posedge clk) disable iff (reset)
        (req_valid && rdy && req.op == op_lookup && !rsp_valid) |-> ##4 rsp_valid)
    else
    begin
        fail_count++;
        $error("rsp_valid did not follow a lookup into an empty queue");
    end

endmodule

bind tlb_top tlb_sva sva_i
(
    .clk(clk),
    .reset(reset),
    .rdy(rdy),
    .req_valid(req_valid),
    .req(req),
    .credit_return(credit_return),
    .rsp_valid(rsp_valid),
    .rsp_deq(rsp_deq)
);

`default_nettype wire

//--- tb/tlb_tb.sv
// Translation cache testbench
`timescale 1ns/10ps
`default_nettype none

module tlb_tb
    import tlb_pkg::*;
();

    // Directed lookups and fills, plus one op per random cycle at most
    localparam int N_RANDOM = 400;
    localparam int N_OPS = 22 + N_RANDOM;
    localparam int CYCLE_LIMIT = 4 * N_OPS + 200;

    logic clk;
    logic reset;
    logic rdy;
    logic req_valid;
    tlb_req_t req;
    logic credit_return;
    logic rsp_valid;
    tlb_rsp_t rsp;
    logic rsp_deq;

    // Reference model with two slots and a victim bit per set
    tlb_entry_t model_slot [N_SETS][2];
    logic model_victim [N_SETS];
    tlb_rsp_t exp_q [$];

    logic [31:0] rng_state;
    int credits;
    int mismatch_count;
    int failure_count;
    int cycle_count = 0;

    tlb_top dut_i
    (
        .clk(clk),
        .reset(reset),
        .rdy(rdy),
        .req_valid(req_valid),
        .req(req),
        .credit_return(credit_return),
        .rsp_valid(rsp_valid),
        .rsp(rsp),
        .rsp_deq(rsp_deq)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #5 clk = ~clk;
    end

    // Hard stop in case the DUT never answers
    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("Timeout after %0d cycles with responses still missing", cycle_count);
            $display("TB FAILED");
            $finish;
        end
    end

    // Xorshift32 step
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [VPN_BITS-1:0] page(input logic [TAG_BITS-1:0] tag,
                                                 input logic [INDEX_BITS-1:0] idx);
        return {tag, idx};
    endfunction

    function automatic tlb_req_t lookup_req(input logic [VPN_BITS-1:0] vpn);
        return '{op: op_lookup, vpn: vpn, ppn: '0};
    endfunction

    function automatic tlb_req_t fill_req(input logic [VPN_BITS-1:0] vpn,
                                          input logic [PPN_BITS-1:0] ppn);
        return '{op: op_fill, vpn: vpn, ppn: ppn};
    endfunction

    // Expected result of a lookup against the model as it stands now
    function automatic tlb_rsp_t model_lookup(input logic [VPN_BITS-1:0] vpn);
        tlb_rsp_t r;
        tlb_entry_t e;
        r = '{hit: 1'b0, vpn: vpn, ppn: '0};
        for (int w = 0; w < 2; w++)
        begin
            e = model_slot[vpn[INDEX_BITS-1:0]][w];
            if (e.valid && e.tag == vpn[VPN_BITS-1:INDEX_BITS])
            begin
                r.hit = 1'b1;
                r.ppn = e.ppn;
            end
        end
        return r;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        mismatch_count++;
        $display("MISMATCH time=%0t signal=%s expected=0x%0h actual=0x%0h",
                 $time, name, expected, actual);
    endtask

    task automatic report_failure(input string msg);
        failure_count++;
        $display("ERROR time=%0t %s", $time, msg);
    endtask

    // Drive one cycle, updating the model on issue and checking on dequeue
    task automatic run_cycle(input logic do_req, input tlb_req_t r, input logic do_deq);
        tlb_rsp_t expected;
        int idx;
        int way;
        req_valid = do_req;
        req = r;
        rsp_deq = 1'b0;
        if (do_req && r.op == op_lookup)
        begin
            exp_q.push_back(model_lookup(r.vpn));
            credits--;
        end
        else if (do_req)
        begin
            // Victim bit picks the way, then flips for the next fill of this set
            idx = int'(r.vpn[INDEX_BITS-1:0]);
            way = int'(model_victim[idx]);
            model_slot[idx][way] = '{valid: 1'b1, tag: r.vpn[VPN_BITS-1:INDEX_BITS], ppn: r.ppn};
            model_victim[idx] = !model_victim[idx];
        end
        if (do_deq && rsp_valid)
        begin
            rsp_deq = 1'b1;
            if (exp_q.size() == 0)
                report_failure("response present with no lookup outstanding");
            else
            begin
                expected = exp_q.pop_front();
                assert (rsp.hit == expected.hit)
                    else report_mismatch("rsp.hit", 64'(expected.hit), 64'(rsp.hit));
                assert (rsp.vpn == expected.vpn)
                    else report_mismatch("rsp.vpn", 64'(expected.vpn), 64'(rsp.vpn));
                assert (rsp.ppn == expected.ppn)
                    else report_mismatch("rsp.ppn", 64'(expected.ppn), 64'(rsp.ppn));
            end
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        rsp_deq = 1'b0;
        // A pulse lasts one cycle, so one look per cycle counts it once
        if (credit_return)
            credits++;
    endtask

    task automatic drain();
        while (exp_q.size() != 0)
            run_cycle(1'b0, '0, 1'b1);
        assert (!rsp_valid) else report_failure("response queue not empty after draining");
    endtask

    initial
    begin
        logic [31:0] r;
        logic [VPN_BITS-1:0] v;
        tlb_rsp_t probe;
        int n;
        reset = 1'b1;
        req_valid = 1'b0;
        req = '0;
        rsp_deq = 1'b0;
        rng_state = 32'd72;
        credits = RSP_DEPTH;
        mismatch_count = 0;
        failure_count = 0;
        for (int s = 0; s < N_SETS; s++)
        begin
            model_slot[s][0] = '0;
            model_slot[s][1] = '0;
            model_victim[s] = 1'b0;
        end
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        // Init walk takes one cycle per set before rdy rises
        n = 0;
        do
        begin
            if (rsp_valid || credit_return)
                report_failure("rsp_valid or credit_return high during the init walk");
            @(posedge clk);
            #1;
            n++;
        end
        while (!rdy && n < 4 * N_SETS);
        assert (n == N_SETS) else report_mismatch("rdy delay", 64'(N_SETS), 64'(n));

        // Nothing filled yet, so every lookup misses
        for (int i = 0; i < 4; i++)
            run_cycle(1'b1, lookup_req(page(TAG_BITS'(next_rand()), INDEX_BITS'(i * 3))), 1'b1);
        drain();

        // Fill, then look the page up on the very next cycle
        run_cycle(1'b1, fill_req(page(15'd100, 5'd4), 16'hbeef), 1'b1);
        run_cycle(1'b1, lookup_req(page(15'd100, 5'd4)), 1'b1);
        drain();

        // Third fill into set 9 evicts the first page and keeps the second
        run_cycle(1'b1, fill_req(page(15'd1, 5'd9), 16'h1111), 1'b1);
        run_cycle(1'b1, fill_req(page(15'd2, 5'd9), 16'h2222), 1'b1);
        run_cycle(1'b1, lookup_req(page(15'd1, 5'd9)), 1'b1);
        run_cycle(1'b1, lookup_req(page(15'd2, 5'd9)), 1'b1);
        run_cycle(1'b1, fill_req(page(15'd3, 5'd9), 16'h3333), 1'b1);
        run_cycle(1'b1, lookup_req(page(15'd1, 5'd9)), 1'b1);
        run_cycle(1'b1, lookup_req(page(15'd2, 5'd9)), 1'b1);
        run_cycle(1'b1, lookup_req(page(15'd3, 5'd9)), 1'b1);
        drain();

        // Hold off dequeues until all credits are spent and the queue is full
        for (int i = 0; i < RSP_DEPTH; i++)
            run_cycle(1'b1, lookup_req(page(TAG_BITS'(i % 4), 5'd9)), 1'b0);
        assert (credits == 0) else report_mismatch("credits", 64'(0), 64'(credits));
        repeat (4) run_cycle(1'b0, '0, 1'b0);
        assert (rsp_valid) else report_failure("rsp_valid low with a full queue");
        drain();
        assert (credits == RSP_DEPTH)
            else report_mismatch("credits", 64'(RSP_DEPTH), 64'(credits));

        // Random mix over eight sets and eight tags, dequeue three cycles in four
        for (int i = 0; i < N_RANDOM; i++)
        begin
            r = next_rand();
            v = '0;
            v[2:0] = r[2:0];
            v[INDEX_BITS+2:INDEX_BITS] = r[5:3];
            probe = model_lookup(v);
            if (r[7:6] == 2'b00 && !probe.hit)
                run_cycle(1'b1, fill_req(v, r[31:16]), r[9:8] != 2'b00);
            else if (r[7:6] != 2'b00 && credits > 0)
                run_cycle(1'b1, lookup_req(v), r[9:8] != 2'b00);
            else
                run_cycle(1'b0, '0, r[9:8] != 2'b00);
        end
        drain();
        assert (credits == RSP_DEPTH)
            else report_mismatch("credits", 64'(RSP_DEPTH), 64'(credits));

        $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatch_count, failure_count, dut_i.sva_i.fail_count);
        if (mismatch_count == 0 && failure_count == 0 && dut_i.sva_i.fail_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/simple_ram.sv
// Simple dual-port RAM
`timescale 1ns/10ps
`default_nettype none

module simple_ram
#(
    parameter int N_ENTRIES = 32,
    parameter int N_DATA_BITS = 64,
    // Extra registers on the read data path
    parameter int N_OUTPUT_REG_STAGES = 0
)
(
    input wire logic clk,

    input wire logic wen,
    input wire logic [$clog2(N_ENTRIES)-1:0] waddr,
    input wire logic [N_DATA_BITS-1:0] wdata,

    input wire logic [$clog2(N_ENTRIES)-1:0] raddr,
    output logic [N_DATA_BITS-1:0] rdata
);

    typedef logic [$clog2(N_ENTRIES)-1:0] addr_t;
    typedef logic [N_DATA_BITS-1:0] data_t;

    data_t mem [N_ENTRIES];
    addr_t raddr_q;
    data_t rd_word;

    // Write port and read address register share the clock edge
    always_ff @(posedge clk)
    begin
        if (wen)
            mem[waddr] <= wdata;
        raddr_q <= raddr;
    end

    // Read from the registered address
    assign rd_word = mem[raddr_q];

    generate
        if (N_OUTPUT_REG_STAGES == 0)
        begin : g_no_out_reg
            assign rdata = rd_word;
        end
        else
        begin : g_out_reg
            data_t pipe [N_OUTPUT_REG_STAGES];

            // The first stage samples before a same-edge write lands, so a
            // read that collides with a write sees the old word
            always_ff @(posedge clk)
            begin
                pipe[0] <= rd_word;
                for (int s = 1; s < N_OUTPUT_REG_STAGES; s++)
                    pipe[s] <= pipe[s-1];
            end

            assign rdata = pipe[N_OUTPUT_REG_STAGES-1];
        end
    endgenerate

endmodule

`default_nettype wire

//--- verilog/simple_ram_init.sv
// RAM with constant fill after reset
`timescale 1ns/10ps
`default_nettype none

module simple_ram_init
#(
    parameter int N_ENTRIES = 32,
    parameter int N_DATA_BITS = 64,
    parameter int N_OUTPUT_REG_STAGES = 0,
    parameter logic [N_DATA_BITS-1:0] INIT_VALUE = '0
)
(
    input wire logic clk,
    input wire logic reset,
    // High once every entry holds INIT_VALUE, and stays high
    output logic rdy,

    input wire logic wen,
    input wire logic [$clog2(N_ENTRIES)-1:0] waddr,
    input wire logic [N_DATA_BITS-1:0] wdata,

    input wire logic [$clog2(N_ENTRIES)-1:0] raddr,
    output logic [N_DATA_BITS-1:0] rdata
);

    typedef logic [$clog2(N_ENTRIES)-1:0] addr_t;

    addr_t init_addr;
    logic ram_wen;
    addr_t ram_waddr;
    logic [N_DATA_BITS-1:0] ram_wdata;

    // The init walk owns the write port until rdy rises
    assign ram_wen = rdy ? wen : 1'b1;
    assign ram_waddr = rdy ? waddr : init_addr;
    assign ram_wdata = rdy ? wdata : INIT_VALUE;

    simple_ram
    #(
        .N_ENTRIES(N_ENTRIES),
        .N_DATA_BITS(N_DATA_BITS),
        .N_OUTPUT_REG_STAGES(N_OUTPUT_REG_STAGES)
    )
    ram_i
    (
        .clk(clk),
        .wen(ram_wen),
        .waddr(ram_waddr),
        .wdata(ram_wdata),
        .raddr(raddr),
        .rdata(rdata)
    );

    // One entry per cycle, so rdy comes up N_ENTRIES cycles after reset
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rdy <= 1'b0;
            init_addr <= '0;
        end
        else if (!rdy)
        begin
            init_addr <= init_addr + 1'b1;
            rdy <= (init_addr == addr_t'(N_ENTRIES - 1));
        end
    end

endmodule

`default_nettype wire

//--- verilog/tlb_pkg.sv
// Translation cache definitions
`default_nettype none

package tlb_pkg;

    // Page number widths on both sides of the translation
    localparam int VPN_BITS = 20;
    localparam int PPN_BITS = 16;

    // Set index comes from the low VPN bits, the tag is whatever remains
    localparam int INDEX_BITS = 5;
    localparam int N_SETS = 32;
    localparam int TAG_BITS = 15;

    // Each way RAM adds this many output registers after the read
    localparam int RAM_OUT_STAGES = 1;

    // Lookup pipe depth: address register, RAM output stages, way hit register
    localparam int LOOKUP_STAGES = RAM_OUT_STAGES + 2;

    // Response queue size, equal to the requester's starting credits
    localparam int RSP_DEPTH = 8;

    typedef enum logic
    {
        op_lookup = 1'b0,
        op_fill = 1'b1
    } tlb_op_t;

    // One request; ppn matters only for a fill
    typedef struct packed
    {
        tlb_op_t op;
        logic [VPN_BITS-1:0] vpn;
        logic [PPN_BITS-1:0] ppn;
    } tlb_req_t;

    // RAM word of one way, all zero means empty
    typedef struct packed
    {
        logic valid;
        logic [TAG_BITS-1:0] tag;
        logic [PPN_BITS-1:0] ppn;
    } tlb_entry_t;

    // Lookup result, ppn is zero on a miss
    typedef struct packed
    {
        logic hit;
        logic [VPN_BITS-1:0] vpn;
        logic [PPN_BITS-1:0] ppn;
    } tlb_rsp_t;

    function automatic logic [INDEX_BITS-1:0] vpn_index(input logic [VPN_BITS-1:0] vpn);
        return vpn[INDEX_BITS-1:0];
    endfunction

    function automatic logic [TAG_BITS-1:0] vpn_tag(input logic [VPN_BITS-1:0] vpn);
        return vpn[VPN_BITS-1:INDEX_BITS];
    endfunction

endpackage

`default_nettype wire

//--- verilog/tlb_resolve.sv
// Translation cache control and response queue
`timescale 1ns/10ps
`default_nettype none

module tlb_resolve
    import tlb_pkg::*;
(
    input wire logic clk,
    input wire logic reset,

    input wire logic req_valid,
    input wire tlb_req_t req,

    // Results and status from the two ways
    input wire logic [1:0] way_rdy,
    input wire logic [1:0] way_hit,
    input wire logic [1:0][PPN_BITS-1:0] way_ppn,

    // Shared read side and per-way write enables
    output logic [INDEX_BITS-1:0] rd_index,
    output logic [TAG_BITS-1:0] cmp_tag,
    output logic [1:0] wen,
    output logic [INDEX_BITS-1:0] windex,
    output tlb_entry_t wentry,

    output logic rdy,
    output logic rsp_valid,
    output tlb_rsp_t rsp,
    input wire logic rsp_deq,
    output logic credit_return
);

    // RSP_DEPTH is a power of two, so the pointers wrap on their own
    typedef logic [$clog2(RSP_DEPTH)-1:0] ptr_t;
    typedef logic [$clog2(RSP_DEPTH):0] count_t;

    logic lookup_acc;
    logic fill_acc;
    logic [LOOKUP_STAGES-1:0] lk_valid;
    logic [VPN_BITS-1:0] lk_vpn [LOOKUP_STAGES];
    logic [N_SETS-1:0] victim;
    logic victim_way;
    tlb_rsp_t rsp_new;
    tlb_rsp_t rsp_mem [RSP_DEPTH];
    ptr_t wr_ptr;
    ptr_t rd_ptr;
    count_t rsp_count;
    logic rsp_enq;
    logic rsp_pop;

    // Both tables must be through their init walk
    assign rdy = &way_rdy;

    assign lookup_acc = req_valid && rdy && (req.op == op_lookup);
    assign fill_acc = req_valid && rdy && (req.op == op_fill);

    // Every request reads its set, fills just ignore the result
    assign rd_index = vpn_index(req.vpn);

    // Stage RAM_OUT_STAGES is the cycle the ways compare returned entries
    assign cmp_tag = vpn_tag(lk_vpn[RAM_OUT_STAGES]);

    // Fill goes to the way the set's victim bit points at
    assign victim_way = victim[vpn_index(req.vpn)];
    assign wen[0] = fill_acc && !victim_way;
    assign wen[1] = fill_acc && victim_way;
    assign windex = vpn_index(req.vpn);
    assign wentry = '{valid: 1'b1, tag: vpn_tag(req.vpn), ppn: req.ppn};

    // Flip the victim bit of a set on each fill into it
    always_ff @(posedge clk)
    begin
        if (reset)
            victim <= '0;
        else if (fill_acc)
            victim[vpn_index(req.vpn)] <= !victim_way;
    end

    // Lookup pipe, valid bits are control and the vpns are payload
    always_ff @(posedge clk)
    begin
        if (reset)
            lk_valid <= '0;
        else
            lk_valid <= {lk_valid[LOOKUP_STAGES-2:0], lookup_acc};
    end

    always_ff @(posedge clk)
    begin
        lk_vpn[0] <= req.vpn;
        for (int s = 1; s < LOOKUP_STAGES; s++)
            lk_vpn[s] <= lk_vpn[s-1];
    end

    // Merge the way hits; way 0 takes precedence if both ever hit
    always_comb
    begin
        rsp_new.hit = |way_hit;
        rsp_new.vpn = lk_vpn[LOOKUP_STAGES-1];
        if (way_hit[0])
            rsp_new.ppn = way_ppn[0];
        else if (way_hit[1])
            rsp_new.ppn = way_ppn[1];
        else
            rsp_new.ppn = '0;
    end

    // Credits bound the lookups in flight, so the queue never overflows
    assign rsp_enq = lk_valid[LOOKUP_STAGES-1];
    assign rsp_valid = (rsp_count != '0);
    assign rsp_pop = rsp_deq && rsp_valid;
    assign rsp = rsp_mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (rsp_enq)
            rsp_mem[wr_ptr] <= rsp_new;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            rsp_count <= '0;
        end
        else
        begin
            if (rsp_enq)
                wr_ptr <= wr_ptr + 1'b1;
            if (rsp_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({rsp_enq, rsp_pop})
                2'b10: rsp_count <= rsp_count + 1'b1;
                2'b01: rsp_count <= rsp_count - 1'b1;
                default: rsp_count <= rsp_count;
            endcase
        end
    end

    // One credit goes back in the cycle after each dequeue
    always_ff @(posedge clk)
    begin
        if (reset)
            credit_return <= 1'b0;
        else
            credit_return <= rsp_pop;
    end

endmodule

`default_nettype wire

//--- verilog/tlb_top.sv
// Two-way translation cache
`timescale 1ns/10ps
`default_nettype none

module tlb_top
    import tlb_pkg::*;
(
    input wire logic clk,
    input wire logic reset,

    // Requester side
    output logic rdy,
    input wire logic req_valid,
    input wire tlb_req_t req,
    output logic credit_return,

    // Consumer side
    output logic rsp_valid,
    output tlb_rsp_t rsp,
    input wire logic rsp_deq
);

    logic [INDEX_BITS-1:0] rd_index;
    logic [TAG_BITS-1:0] cmp_tag;
    logic [1:0] way_wen;
    logic [INDEX_BITS-1:0] windex;
    tlb_entry_t wentry;
    logic [1:0] way_hit;
    logic [1:0][PPN_BITS-1:0] way_ppn;
    logic [1:0] way_rdy;

    // Both ways see the same read and write buses, only wen differs
    tlb_way way0_i
    (
        .clk(clk),
        .reset(reset),
        .rd_index(rd_index),
        .cmp_tag(cmp_tag),
        .wen(way_wen[0]),
        .windex(windex),
        .wentry(wentry),
        .hit(way_hit[0]),
        .hit_ppn(way_ppn[0]),
        .rdy(way_rdy[0])
    );

    tlb_way way1_i
    (
        .clk(clk),
        .reset(reset),
        .rd_index(rd_index),
        .cmp_tag(cmp_tag),
        .wen(way_wen[1]),
        .windex(windex),
        .wentry(wentry),
        .hit(way_hit[1]),
        .hit_ppn(way_ppn[1]),
        .rdy(way_rdy[1])
    );

    // Request decode, victim choice, response queue and credits
    tlb_resolve resolve_i
    (
        .clk(clk),
        .reset(reset),
        .req_valid(req_valid),
        .req(req),
        .way_rdy(way_rdy),
        .way_hit(way_hit),
        .way_ppn(way_ppn),
        .rd_index(rd_index),
        .cmp_tag(cmp_tag),
        .wen(way_wen),
        .windex(windex),
        .wentry(wentry),
        .rdy(rdy),
        .rsp_valid(rsp_valid),
        .rsp(rsp),
        .rsp_deq(rsp_deq),
        .credit_return(credit_return)
    );

endmodule

`default_nettype wire

//--- verilog/tlb_way.sv
// Translation cache way
`timescale 1ns/10ps
`default_nettype none

module tlb_way
    import tlb_pkg::*;
(
    input wire logic clk,
    input wire logic reset,

    // Read side, index now and tag when the entry comes back
    input wire logic [INDEX_BITS-1:0] rd_index,
    input wire logic [TAG_BITS-1:0] cmp_tag,

    // Fill write port
    input wire logic wen,
    input wire logic [INDEX_BITS-1:0] windex,
    input wire tlb_entry_t wentry,

    output logic hit,
    output logic [PPN_BITS-1:0] hit_ppn,
    output logic rdy
);

    tlb_entry_t rd_entry;

    // Entry RAM, cleared to invalid by the init walk
    simple_ram_init
    #(
        .N_ENTRIES(N_SETS),
        .N_DATA_BITS($bits(tlb_entry_t)),
        .N_OUTPUT_REG_STAGES(RAM_OUT_STAGES),
        .INIT_VALUE('0)
    )
    entries_i
    (
        .clk(clk),
        .reset(reset),
        .rdy(rdy),
        .wen(wen),
        .waddr(windex),
        .wdata(wentry),
        .raddr(rd_index),
        .rdata(rd_entry)
    );

    // Tag compare on the entry leaving the RAM output stage
    always_ff @(posedge clk)
    begin
        if (reset)
            hit <= 1'b0;
        else
            hit <= rd_entry.valid && (rd_entry.tag == cmp_tag);
    end

    // The ppn travels unqualified, resolve looks at it only on a hit
    always_ff @(posedge clk)
    begin
        hit_ppn <= rd_entry.ppn;
    end

endmodule

`default_nettype wire
